//--- bench/axi_mem_model.sv
// AXI read memory model
// Three independent read ports, one burst each at a time, data derived
// from the byte address and the port, with one injectable error address

`timescale 1ns/1ps
`include "map_defs.svh"

module axi_mem_model (
  input  logic                clk,
  input  logic                rst_n,
  input  map_pkg::ar_t        ar [`MAP_NUM],
  output logic [`MAP_NUM-1:0] arready,
  output map_pkg::r_t         r [`MAP_NUM],
  input  logic [`MAP_NUM-1:0] rready,
  input  logic                err_en,    // Enables the error response
  input  logic [1:0]          err_map,   // Port that sees it
  input  map_pkg::addr_t      err_addr   // Beat address that gets SLVERR
);

  // Byte k of address a is (a + k) xor (port * 0x40)
  function automatic map_pkg::word_t word_at(input map_pkg::addr_t a, input int m);
    map_pkg::word_t w;
    for (int k = 0; k < `PIX_PER_WORD; k++) begin
      w[k*`PIX_W +: `PIX_W] = 8'(a + map_pkg::addr_t'(k)) ^ 8'(m * 'h40);
    end
    return w;
  endfunction

  // --------------------------------------------------------------------------
  // One read port per map
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < `MAP_NUM; i++) begin : g_port
    logic            busy;   // Burst in flight
    map_pkg::addr_t  addr;   // Current beat address
    map_pkg::burst_t left;   // Beats after this one

    assign arready[i] = !busy;  // Accept only between bursts

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        busy <= 1'b0;
        addr <= '0;
        left <= '0;
      end else if (!busy) begin
        if (ar[i].arvalid) begin
          busy <= 1'b1;
          addr <= ar[i].araddr;
          left <= ar[i].arlen;
        end
      end else if (rready[i]) begin
        addr <= addr + 32'd8;            // INCR, 8 byte beats
        if (left == '0) busy <= 1'b0;
        else left <= left - 1'b1;
      end
    end

    assign r[i] = '{rdata:  word_at(addr, i),
                    rresp:  (err_en && err_map == 2'(i) && addr == err_addr) ? 2'd2 : 2'd0,
                    rlast:  (left == '0),
                    rvalid: busy};
  end

endmodule

//--- bench/tb_axi2frame.sv
// AXI to frame testbench
// Directed frames through the three map lanes against the AXI memory
// model, checking pixels, markers, burst addresses and status

`timescale 1ns/1ps
`include "map_defs.svh"

module tb_axi2frame;

  // Pixels over all frames below, sizes the watchdog
  localparam int TOTAL_PIX  = 32 + 48 + 48 + 64 + 2 * 32 + 2 * 32;
  localparam int MAX_CYCLES = TOTAL_PIX * 4 + 1500;

  logic                clk;
  logic                rst_n;
  map_pkg::cfg_t       cfg;
  map_pkg::map_cfg_t   map_cfg [`MAP_NUM];
  map_pkg::ar_t        ar [`MAP_NUM];
  logic [`MAP_NUM-1:0] arready;
  map_pkg::r_t         r [`MAP_NUM];
  logic [`MAP_NUM-1:0] rready;
  map_pkg::frm_t       frm;
  logic                frm_rdy;
  map_pkg::sts_t       sts;
  logic                err_en;
  logic [1:0]          err_map;
  map_pkg::addr_t      err_addr;

  int                  err_cnt;
  int                  cycles;
  int                  seed_val;
  logic                rdy_rand;           // Random frm_rdy when set
  int                  arvalid_cnt [`MAP_NUM];
  map_pkg::frm_t       beat_q [$];         // Accepted output beats
  map_pkg::addr_t      ar_addr_q [$];      // Accepted AR addresses
  int                  ar_map_q [$];       // Channel of each address

  axi2frame_top u_axi2frame_top (
    .clk (clk), .rst_n (rst_n), .cfg (cfg), .map_cfg (map_cfg),
    .ar (ar), .arready (arready), .r (r), .rready (rready),
    .frm (frm), .frm_rdy (frm_rdy), .sts (sts)
  );

  axi_mem_model u_mem (
    .clk (clk), .rst_n (rst_n), .ar (ar), .arready (arready), .r (r),
    .rready (rready), .err_en (err_en), .err_map (err_map), .err_addr (err_addr)
  );

  always #20 clk = ~clk;  // 40 ns period

  always @(posedge clk) frm_rdy <= rdy_rand ? 1'($urandom % 2) : 1'b1;

  // --------------------------------------------------------------------------
  // Monitors and watchdog
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n && frm.val && frm_rdy) beat_q.push_back(frm);
    for (int i = 0; i < `MAP_NUM; i++) begin
      if (rst_n && ar[i].arvalid) arvalid_cnt[i]++;
      if (rst_n && ar[i].arvalid && arready[i]) begin
        ar_addr_q.push_back(ar[i].araddr);
        ar_map_q.push_back(i);
        if (ar[i].arlen >= cfg.max_burst) begin  // arlen + 1 above max_burst
          err_cnt++;
          $display("Burst of %0d beats on map %0d is longer than max_burst %0d",
                   ar[i].arlen + 1, i, cfg.max_burst);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT never finished the frame", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic compare_pix(input string name, input map_pkg::pix_t got,
                             input map_pkg::pix_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_addr(input string name, input map_pkg::addr_t got,
                              input map_pkg::addr_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_sts(input string name, input map_pkg::sts_t got,
                             input map_pkg::sts_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  // --------------------------------------------------------------------------
  // Frame helpers
  // --------------------------------------------------------------------------
  // Expected merged pixel at line y, column x
  function automatic map_pkg::pix_t exp_pix(input int y, input int x);
    map_pkg::pix_t  p;
    map_pkg::addr_t a;
    p = '0;
    for (int m = 0; m < `MAP_NUM; m++) begin
      a = map_cfg[m].base + map_pkg::addr_t'(y * int'(cfg.stride) + x);
      if (map_cfg[m].en) p[m*`PIX_W +: `PIX_W] = a[7:0] ^ 8'(m * 'h40);
    end
    return p;
  endfunction

  // Bus handshakes, frame valid and status all low out of reset
  task automatic check_reset_outputs;
    @(negedge clk);
    for (int i = 0; i < `MAP_NUM; i++) begin
      compare_flag($sformatf("ar[%0d].arvalid", i), ar[i].arvalid, 1'b0);
      compare_flag($sformatf("rready[%0d]", i), rready[i], 1'b0);
    end
    compare_flag("frm.val", frm.val, 1'b0);
    compare_sts("sts after reset", sts, '0);
  endtask

  task automatic setup_frame(input logic [`MAP_NUM-1:0] en, input int w, input int h,
                             input int stride, input int mb, input logic rnd);
    @(negedge clk);
    beat_q.delete();
    ar_addr_q.delete();
    ar_map_q.delete();
    for (int i = 0; i < `MAP_NUM; i++) arvalid_cnt[i] = 0;
    rdy_rand = rnd;
    @(posedge clk);
    cfg.img_width  <= map_pkg::dim_t'(w);
    cfg.img_height <= map_pkg::dim_t'(h);
    cfg.stride     <= map_pkg::dim_t'(stride);
    cfg.max_burst  <= map_pkg::burst_t'(mb);
    for (int i = 0; i < `MAP_NUM; i++) map_cfg[i].en <= en[i];
  endtask

  // Start fires one cycle after the edge, status clears one cycle later
  task automatic kick_frame;
    @(posedge clk);
    cfg.blk_en <= 1'b1;
    repeat (2) @(posedge clk);
    cfg.blk_en <= 1'b0;
    @(negedge clk);
  endtask

  task automatic finish_frame;
    int n;
    int w;
    int x;
    int y;
    @(negedge clk);
    while (!sts.idle) @(negedge clk);   // Watchdog bounds this wait
    w = int'(cfg.img_width);
    n = w * int'(cfg.img_height);
    if (beat_q.size() != n) begin
      err_cnt++;
      $display("Frame delivered %0d beats, %0d expected", beat_q.size(), n);
    end
    for (int i = 0; i < beat_q.size() && i < n; i++) begin
      y = i / w;
      x = i % w;
      compare_pix($sformatf("frm.data beat %0d", i), beat_q[i].data, exp_pix(y, x));
      compare_flag("frm.sol", beat_q[i].sol, x == 0);
      compare_flag("frm.eol", beat_q[i].eol, x == w - 1);
      compare_flag("frm.sof", beat_q[i].sof, i == 0);
      compare_flag("frm.eof", beat_q[i].eof, i == n - 1);
    end
  endtask

  task automatic check_end_sts(input logic exp_err, input logic exp_int);
    compare_sts("sts", sts, '{axi_error: exp_err, read_done: 1'b1,
                              idle: 1'b1, frm_int: exp_int});
  endtask

  task automatic ack_int;
    @(posedge clk);
    cfg.int_ack <= 1'b1;
    @(posedge clk);
    cfg.int_ack <= 1'b0;
    @(negedge clk);
  endtask

  // Burst addresses per channel against line and burst walk
  task automatic check_addrs;
    map_pkg::addr_t exp_q [$];
    int             left;
    int             off;
    int             len;
    int             k;
    for (int m = 0; m < `MAP_NUM; m++) begin
      exp_q.delete();
      for (int y = 0; y < int'(cfg.img_height) && map_cfg[m].en; y++) begin
        left = int'(cfg.img_width) / `PIX_PER_WORD;
        off  = 0;
        while (left > 0) begin
          len = (left < int'(cfg.max_burst)) ? left : int'(cfg.max_burst);
          exp_q.push_back(map_cfg[m].base + map_pkg::addr_t'(y * int'(cfg.stride) + off));
          off  += len * 8;
          left -= len;
        end
      end
      k = 0;
      for (int j = 0; j < ar_addr_q.size(); j++) begin
        if (ar_map_q[j] == m) begin
          if (k < exp_q.size())
            compare_addr($sformatf("araddr[%0d] burst %0d", m, k), ar_addr_q[j], exp_q[k]);
          k++;
        end
      end
      if (k != exp_q.size()) begin
        err_cnt++;
        $display("Map %0d issued %0d bursts, %0d expected", m, k, exp_q.size());
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic single_map_frame;
    setup_frame(3'b001, 16, 2, 16, 4, 1'b0);
    kick_frame();
    finish_frame();
    check_addrs();
    check_end_sts(1'b0, 1'b1);
    ack_int();
  endtask

  task automatic three_map_bursts;
    setup_frame(3'b111, 16, 3, 40, 1, 1'b0);   // Stride past line end
    kick_frame();
    finish_frame();
    check_addrs();
    check_end_sts(1'b0, 1'b1);
    ack_int();
  endtask

  task automatic random_stall_frame;
    setup_frame(3'b111, 16, 3, 40, 1, 1'b1);
    kick_frame();
    finish_frame();                            // Same sequence, no loss
    check_end_sts(1'b0, 1'b1);
    ack_int();
    rdy_rand = 1'b0;
  endtask

  task automatic disabled_map_frame;
    setup_frame(3'b101, 32, 2, 32, 2, 1'b0);
    kick_frame();
    finish_frame();
    foreach (beat_q[i])
      compare_pix("frm.data[15:8]", beat_q[i].data & 24'h00ff00, '0);
    if (arvalid_cnt[1] != 0) begin
      err_cnt++;
      $display("Disabled map 1 raised arvalid in %0d cycles", arvalid_cnt[1]);
    end
    check_addrs();
    check_end_sts(1'b0, 1'b1);
    ack_int();
  endtask

  task automatic error_response_frame;
    @(posedge clk);
    err_en   <= 1'b1;
    err_map  <= 2'd2;
    err_addr <= map_cfg[2].base + 32'd8;       // Second word of line 0
    setup_frame(3'b111, 16, 2, 16, 4, 1'b0);
    kick_frame();
    finish_frame();
    check_end_sts(1'b1, 1'b1);
    ack_int();
    check_end_sts(1'b1, 1'b0);                 // Error still held
    @(posedge clk);
    err_en <= 1'b0;
    setup_frame(3'b111, 16, 2, 16, 4, 1'b0);
    kick_frame();
    compare_sts("sts after start", sts, '0);
    finish_frame();
    check_end_sts(1'b0, 1'b1);
    ack_int();
  endtask

  task automatic irq_and_idle_status;
    setup_frame(3'b011, 16, 2, 16, 8, 1'b0);
    kick_frame();
    finish_frame();
    check_end_sts(1'b0, 1'b1);
    ack_int();
    check_end_sts(1'b0, 1'b0);
    repeat (8) @(negedge clk);
    check_end_sts(1'b0, 1'b0);                 // Idle holds until start
    setup_frame(3'b011, 16, 2, 16, 8, 1'b0);
    kick_frame();
    compare_sts("sts after start", sts, '0);
    finish_frame();
    check_end_sts(1'b0, 1'b1);
    ack_int();
  endtask

  initial begin
    seed_val = $urandom(76913);
    clk      = 1'b0;
    rst_n    = 1'b0;
    cfg      = '0;
    frm_rdy  = 1'b1;
    rdy_rand = 1'b0;
    err_en   = 1'b0;
    err_map  = 2'd0;
    err_addr = '0;
    err_cnt  = 0;
    cycles   = 0;
    map_cfg[0] = '{en: 1'b0, base: 32'h0000_1000};
    map_cfg[1] = '{en: 1'b0, base: 32'h0000_2238};
    map_cfg[2] = '{en: 1'b0, base: 32'h0000_3470};
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    check_reset_outputs();
    single_map_frame();
    three_map_bursts();
    random_stall_frame();
    disabled_map_frame();
    error_response_frame();
    irq_and_idle_status();
    $display("Run finished with %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- hdl/axi2frame_top.sv
// AXI to frame top level
// Three AXI read lanes, one per map, merged into a single 24 bit
// frame stream under a common control block

`timescale 1ns/1ps
`include "map_defs.svh"

module axi2frame_top (
  input  logic                clk,
  input  logic                rst_n,
  input  map_pkg::cfg_t       cfg,
  input  map_pkg::map_cfg_t   map_cfg [`MAP_NUM],
  output map_pkg::ar_t        ar [`MAP_NUM],
  input  logic [`MAP_NUM-1:0] arready,
  input  map_pkg::r_t         r [`MAP_NUM],
  output logic [`MAP_NUM-1:0] rready,
  output map_pkg::frm_t       frm,
  input  logic                frm_rdy,
  output map_pkg::sts_t       sts
);

  logic                start;
  logic [`MAP_NUM-1:0] lane_act;
  logic [`MAP_NUM-1:0] lane_done;
  logic [`MAP_NUM-1:0] lane_err;
  logic [`MAP_NUM-1:0] fifo_empty;
  logic [`MAP_NUM-1:0] fifo_pop;
  map_pkg::word_t      fifo_word [`MAP_NUM];
  logic                frame_end;

  map_ctrl u_map_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .map_cfg   (map_cfg),
    .lane_done (lane_done),
    .lane_err  (lane_err),
    .frame_end (frame_end),
    .start     (start),
    .lane_act  (lane_act),
    .sts       (sts)
  );

  // --------------------------------------------------------------------------
  // One fetch lane per map
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < `MAP_NUM; i++) begin : g_lane
    map_fetch u_map_fetch (
      .clk        (clk),
      .rst_n      (rst_n),
      .start      (start),
      .act        (lane_act[i]),
      .mcfg       (map_cfg[i]),
      .cfg        (cfg),
      .ar         (ar[i]),
      .arready    (arready[i]),
      .r          (r[i]),
      .rready     (rready[i]),
      .fifo_pop   (fifo_pop[i]),
      .fifo_word  (fifo_word[i]),
      .fifo_empty (fifo_empty[i]),
      .done       (lane_done[i]),
      .err        (lane_err[i])
    );
  end

  pixel_merge u_pixel_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .lane_act   (lane_act),
    .cfg        (cfg),
    .fifo_empty (fifo_empty),
    .fifo_word  (fifo_word),
    .fifo_pop   (fifo_pop),
    .frm        (frm),
    .frm_rdy    (frm_rdy),
    .frame_end  (frame_end)
  );

endmodule

//--- hdl/map_ctrl.sv
// Map read control
// Turns the block enable edge into a start pulse, latches the active
// lanes and keeps the run status and frame interrupt

`timescale 1ns/1ps
`include "map_defs.svh"

module map_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  map_pkg::cfg_t         cfg,
  input  map_pkg::map_cfg_t     map_cfg [`MAP_NUM],
  input  logic [`MAP_NUM-1:0]   lane_done,  // Per lane, level
  input  logic [`MAP_NUM-1:0]   lane_err,   // Per lane, pulse
  input  logic                  frame_end,  // Eof beat accepted
  output logic                  start,
  output logic [`MAP_NUM-1:0]   lane_act,
  output map_pkg::sts_t         sts
);

  logic                blk_en_d;   // Enable delayed for edge detect
  logic                en_rise;
  logic [`MAP_NUM-1:0] map_en;     // Enables gathered from config
  logic                all_done;   // Every lane done or unused
  logic                run;        // Frame in progress
  logic                rd_done_q;
  logic                axi_err_q;
  logic                idle_q;
  logic                frm_int_q;

  always_comb begin
    for (int i = 0; i < `MAP_NUM; i++) begin
      map_en[i] = map_cfg[i].en;
    end
  end

  assign en_rise  = cfg.blk_en & ~blk_en_d;
  assign all_done = &(lane_done | ~lane_act);

  // --------------------------------------------------------------------------
  // Start and lane activation
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      blk_en_d <= 1'b0;
      start    <= 1'b0;
      lane_act <= '0;
    end else begin
      blk_en_d <= cfg.blk_en;
      start    <= en_rise;               // One cycle pulse
      if (en_rise) lane_act <= map_en;   // Valid together with start
    end
  end

  // --------------------------------------------------------------------------
  // Status
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run       <= 1'b0;
      rd_done_q <= 1'b0;
      axi_err_q <= 1'b0;
      idle_q    <= 1'b0;
    end else if (start) begin
      run       <= 1'b1;
      rd_done_q <= 1'b0;
      axi_err_q <= 1'b0;                 // New frame, fresh error flag
      idle_q    <= 1'b0;
    end else begin
      if (run && all_done) rd_done_q <= 1'b1;
      if (|lane_err) axi_err_q <= 1'b1;  // Sticky
      if (frame_end) run <= 1'b0;
      if (frame_end && all_done) idle_q <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frm_int_q <= 1'b0;
    end else if (cfg.int_ack) begin
      frm_int_q <= 1'b0;                 // Ack wins over a new frame end
    end else if (frame_end && all_done) begin
      frm_int_q <= 1'b1;
    end
  end

  assign sts = '{axi_error: axi_err_q, read_done: rd_done_q,
                 idle: idle_q, frm_int: frm_int_q};

  // Merger must not finish a frame that control already closed
  a_no_end_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    frame_end |-> !idle_q);

endmodule

//--- hdl/map_defs.svh
// Map reader constants
// Bus, pixel and image field widths shared by the AXI to frame path

`ifndef MAP_DEFS_SVH
`define MAP_DEFS_SVH

// --------------------------------------------------------------------------
// Data path
// --------------------------------------------------------------------------
`define MAP_NUM       3    // Maps read in parallel
`define MEM_W         64   // Memory word width
`define PIX_W         8    // Bits per map pixel
`define PIX_PER_WORD  8    // Pixels packed in one word

// --------------------------------------------------------------------------
// Bus and configuration fields
// --------------------------------------------------------------------------
`define ADDR_W        32   // Byte address
`define DIM_W         11   // Width, height and stride fields
`define BURST_W       8    // AXI arlen field

// --------------------------------------------------------------------------
// Lane buffering
// --------------------------------------------------------------------------
`define FIFO_DEPTH    16   // Words per lane FIFO
`define FIFO_AW       4    // Pointer width for FIFO_DEPTH

`endif

//--- hdl/map_fetch.sv
// Map fetch lane
// Reads one map line by line over AXI in INCR bursts of 8 byte beats,
// one burst outstanding, and queues the words in a local FIFO

`timescale 1ns/1ps
`include "map_defs.svh"

module map_fetch (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  logic               act,         // Lane used in this frame
  input  map_pkg::map_cfg_t  mcfg,
  input  map_pkg::cfg_t      cfg,
  output map_pkg::ar_t       ar,
  input  logic               arready,
  input  map_pkg::r_t        r,
  output logic               rready,
  input  logic               fifo_pop,
  output map_pkg::word_t     fifo_word,
  output logic               fifo_empty,
  output logic               done,        // Last beat of frame queued
  output logic               err          // Pulse on error response
);

  map_pkg::fetch_state_t state;
  map_pkg::addr_t        line_addr;    // Start of current line
  map_pkg::addr_t        burst_addr;   // Address of next burst
  map_pkg::dim_t         words_left;   // Words not yet requested in line
  map_pkg::dim_t         line_cnt;
  map_pkg::dim_t         words_line;
  map_pkg::dim_t         burst_len;    // Beats in the pending burst
  map_pkg::burst_t       arlen;
  logic                  fifo_full;
  logic                  beat;

  assign words_line = map_pkg::dim_t'(cfg.img_width >> 3);  // 8 pixels per word
  assign burst_len  = (words_left < map_pkg::dim_t'(cfg.max_burst)) ?
                      words_left : map_pkg::dim_t'(cfg.max_burst);
  assign arlen      = map_pkg::burst_t'(burst_len - 1'b1);
  assign rready     = (state == map_pkg::DATA) && !fifo_full;
  assign beat       = r.rvalid && rready;

  assign ar = '{araddr: burst_addr, arlen: arlen,
                arvalid: (state == map_pkg::ADDR)};

  // --------------------------------------------------------------------------
  // Line and burst walker
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= map_pkg::IDLE;
      line_addr  <= '0;
      burst_addr <= '0;
      words_left <= '0;
      line_cnt   <= '0;
      done       <= 1'b0;
    end else if (start) begin
      state      <= act ? map_pkg::ADDR : map_pkg::IDLE;  // Unused lane stays quiet
      line_addr  <= mcfg.base;
      burst_addr <= mcfg.base;
      words_left <= words_line;
      line_cnt   <= '0;
      done       <= 1'b0;
    end else begin
      case (state)
        map_pkg::ADDR: begin
          if (arready) begin
            state      <= map_pkg::DATA;
            words_left <= words_left - burst_len;
            burst_addr <= burst_addr + (map_pkg::addr_t'(burst_len) << 3);
          end
        end
        map_pkg::DATA: begin
          if (beat && r.rlast) begin
            if (words_left != '0) begin
              state <= map_pkg::ADDR;     // More bursts in this line
            end else if (line_cnt == cfg.img_height - 1'b1) begin
              state <= map_pkg::IDLE;
              done  <= 1'b1;              // Last word of the frame queued
            end else begin
              state <= map_pkg::NEXT;
            end
          end
        end
        map_pkg::NEXT: begin
          line_addr  <= line_addr + map_pkg::addr_t'(cfg.stride);
          burst_addr <= line_addr + map_pkg::addr_t'(cfg.stride);
          words_left <= words_line;
          line_cnt   <= line_cnt + 1'b1;
          state      <= map_pkg::ADDR;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) err <= 1'b0;
    else        err <= beat && (r.rresp != 2'b00);  // SLVERR or DECERR
  end

  word_fifo u_word_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .clr       (start),
    .push      (beat),
    .push_data (r.rdata),
    .pop       (fifo_pop),
    .pop_data  (fifo_word),
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

  a_burst_limit: assert property (@(posedge clk) disable iff (!rst_n)
    ar.arvalid |-> ({1'b0, ar.arlen} + 9'd1) <= {1'b0, cfg.max_burst});

endmodule

//--- hdl/map_pkg.sv
// Map reader types
// Vector typedefs and the packed buses between the fetch lanes,
// the control block and the pixel merger

`include "map_defs.svh"

package map_pkg;

  typedef logic [`ADDR_W-1:0]           addr_t;   // Byte address
  typedef logic [`DIM_W-1:0]            dim_t;    // Width, height, stride
  typedef logic [`BURST_W-1:0]          burst_t;  // Burst length field
  typedef logic [`MEM_W-1:0]            word_t;   // Memory word
  typedef logic [`MAP_NUM*`PIX_W-1:0]   pix_t;    // Merged output pixel

  typedef struct packed {
    logic   blk_en;      // Rising edge starts a frame
    dim_t   img_width;   // Pixels per line, multiple of 8
    dim_t   img_height;  // Lines per frame
    dim_t   stride;      // Bytes between line starts
    burst_t max_burst;   // Beats per burst, upper bound
    logic   int_ack;     // Clears frame interrupt
  } cfg_t;

  typedef struct packed {
    logic  en;    // Map read enable
    addr_t base;  // First line address
  } map_cfg_t;

  typedef struct packed {
    addr_t  araddr;
    burst_t arlen;
    logic   arvalid;
  } ar_t;

  typedef struct packed {
    word_t      rdata;
    logic [1:0] rresp;
    logic       rlast;
    logic       rvalid;
  } r_t;

  typedef struct packed {
    logic val;
    pix_t data;  // Map 0 in low byte
    logic sof;
    logic eof;
    logic sol;
    logic eol;
  } frm_t;

  typedef enum logic [1:0] {IDLE, ADDR, DATA, NEXT} fetch_state_t;

  typedef struct packed {
    logic axi_error;  // Sticky until next start
    logic read_done;  // All active maps read
    logic idle;       // Frame fully sent
    logic frm_int;    // Frame interrupt
  } sts_t;

endpackage

//--- hdl/pixel_merge.sv
// Pixel merger
// Pops one word from every active lane at once, shifts the pixels out
// one per accepted beat and adds line and frame markers

`timescale 1ns/1ps
`include "map_defs.svh"

module pixel_merge (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic [`MAP_NUM-1:0] lane_act,
  input  map_pkg::cfg_t       cfg,
  input  logic [`MAP_NUM-1:0] fifo_empty,
  input  map_pkg::word_t      fifo_word [`MAP_NUM],
  output logic [`MAP_NUM-1:0] fifo_pop,
  output map_pkg::frm_t       frm,
  input  logic                frm_rdy,
  output logic                frame_end   // Eof beat accepted
);

  localparam int CNT_W = $clog2(`PIX_PER_WORD + 1);

  map_pkg::word_t  sh [`MAP_NUM];     // Per lane pixel shifters
  logic [CNT_W-1:0] pix_left;         // Pixels still in shifters
  map_pkg::dim_t   col;
  map_pkg::dim_t   line;
  logic            run;
  logic            all_rdy;           // Every active lane has a word
  logic            acc;               // Beat accepted
  logic            load;
  logic            sol;
  logic            eol;
  logic            sof;
  logic            eof;
  map_pkg::pix_t   pix;

  assign all_rdy = &(~fifo_empty | ~lane_act);
  assign acc     = frm.val && frm_rdy;
  assign sol     = (col == '0);
  assign eol     = (col == cfg.img_width - 1'b1);
  assign sof     = sol && (line == '0);
  assign eof     = eol && (line == cfg.img_height - 1'b1);

  // Refill on the last pixel's accept keeps the stream gapless
  assign load = run && all_rdy &&
                ((pix_left == '0) || ((pix_left == CNT_W'(1)) && acc && !eof));
  assign fifo_pop  = {`MAP_NUM{load}} & lane_act;
  assign frame_end = acc && eof;

  always_comb begin
    for (int i = 0; i < `MAP_NUM; i++) begin
      pix[i*`PIX_W +: `PIX_W] = sh[i][`PIX_W-1:0];   // Lowest byte goes first
    end
  end

  assign frm = '{val: (pix_left != '0), data: pix,
                 sof: sof, eof: eof, sol: sol, eol: eol};

  // --------------------------------------------------------------------------
  // Shifters
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int i = 0; i < `MAP_NUM; i++) begin
      if (load) sh[i] <= lane_act[i] ? fifo_word[i] : '0;  // Unused map reads zero
      else if (acc) sh[i] <= sh[i] >> `PIX_W;
    end
  end

  // --------------------------------------------------------------------------
  // Beat, column and line counters
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run      <= 1'b0;
      pix_left <= '0;
      col      <= '0;
      line     <= '0;
    end else if (start) begin
      run      <= 1'b1;
      pix_left <= '0;
      col      <= '0;
      line     <= '0;
    end else begin
      if (load) pix_left <= CNT_W'(`PIX_PER_WORD);
      else if (acc) pix_left <= pix_left - 1'b1;
      if (acc) begin
        if (eol) begin
          col  <= '0;
          line <= eof ? '0 : line + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
      end
      if (frame_end) run <= 1'b0;     // Nothing more to pop
    end
  end

  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    frm.val && !frm_rdy && !start |=> $stable(frm.data));

endmodule

//--- hdl/word_fifo.sv
// Lane word FIFO
// Register array buffer between one AXI read lane and the pixel merger,
// with show-ahead read data

`timescale 1ns/1ps
`include "map_defs.svh"

module word_fifo (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          clr,        // Empty at frame start
  input  logic          push,
  input  map_pkg::word_t push_data,
  input  logic          pop,
  output map_pkg::word_t pop_data,
  output logic          empty,
  output logic          full
);

  map_pkg::word_t      mem [`FIFO_DEPTH];
  logic [`FIFO_AW-1:0] wr_ptr;
  logic [`FIFO_AW-1:0] rd_ptr;
  logic [`FIFO_AW:0]   count;       // One extra bit for the full case

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clr) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  assign pop_data = mem[rd_ptr];    // Head word, no read latency
  assign empty    = (count == '0);
  assign full     = (count == (`FIFO_AW+1)'(`FIFO_DEPTH));

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push && !clr |-> !full);
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop && !clr |-> !empty);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the AXI to frame testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_axi2frame -Mdir obj_dir -o tb_axi2frame > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_axi2frame > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
  exit 1
fi
exit 0

//--- sources.f
+incdir+hdl
hdl/map_pkg.sv
hdl/word_fifo.sv
hdl/map_ctrl.sv
hdl/map_fetch.sv
hdl/pixel_merge.sv
hdl/axi2frame_top.sv
bench/axi_mem_model.sv
bench/tb_axi2frame.sv
